/* mem_pkg.sv */
package mem_pkg;

  // bus widths shared by the interface and all bus agents
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // default sram depth in words, must be a power of two
  localparam int MEM_WORDS_DEF = 1024;

  // load function codes
  // signed variants extend bit 7 or bit 15 of the selected data
  typedef enum logic [2:0] {
    LD_B  = 3'd0,
    LD_BU = 3'd1,
    LD_H  = 3'd2,
    LD_HU = 3'd3,
    LD_W  = 3'd4
  } ld_func_e;

  // store function codes
  typedef enum logic [2:0] {
    ST_B = 3'd0,
    ST_H = 3'd1,
    ST_W = 3'd2
  } st_func_e;

endpackage

/* axi_lite_if.sv */
`timescale 1ns/1ps

interface axi_lite_if;
  import mem_pkg::*;

  // write address
  logic                awvalid;
  logic                awready;
  logic [ADDR_W-1:0]   awaddr;

  // write data
  logic                wvalid;
  logic                wready;
  logic [DATA_W-1:0]   wdata;
  logic [DATA_W/8-1:0] wstrb;

  // write response, code is always okay so not carried
  logic                bvalid;
  logic                bready;

  // read address
  logic                arvalid;
  logic                arready;
  logic [ADDR_W-1:0]   araddr;

  // read data
  logic                rvalid;
  logic                rready;
  logic [DATA_W-1:0]   rdata;

  modport master (
    output awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
    input  awready, wready, bvalid, arready, rvalid, rdata
  );

  modport slave (
    input  awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
    output awready, wready, bvalid, arready, rvalid, rdata
  );

endinterface

/* lsu.sv */
`timescale 1ns/1ps

module lsu (
  input  logic              clk,
  input  logic              rstn,
  // load request and reply
  input  logic [31:0]       raddr,
  input  mem_pkg::ld_func_e rfunc,
  input  logic              rreq_valid,
  output logic              rreq_ready,
  output logic [31:0]       rdata,
  output logic              rres_valid,
  input  logic              rres_ready,
  // store request and reply
  input  logic [31:0]       waddr,
  input  logic [31:0]       wdata,
  input  mem_pkg::st_func_e wfunc,
  input  logic              wreq_valid,
  output logic              wreq_ready,
  output logic              wres_valid,
  input  logic              wres_ready,
  axi_lite_if.master        bus
);
  import mem_pkg::*;

  // load side state, captured when AR is accepted
  logic [1:0]  ld_align;
  ld_func_e    ld_func;
  logic [31:0] ld_shifted;
  logic [31:0] ld_result;

  // store side
  logic [31:0] st_data;
  logic [3:0]  st_mask;
  logic [3:0]  st_strb;
  logic        aw_pend;
  logic        w_pend;

  // read address goes straight out
  assign bus.arvalid = rreq_valid;
  assign bus.araddr  = raddr;
  assign rreq_ready  = bus.arready;

  always_ff @(posedge clk) begin
    if (bus.arvalid && bus.arready) begin
      ld_align <= raddr[1:0];
      ld_func  <= rfunc;
    end
  end

  // bring the addressed byte down to lane 0
  always_comb begin
    case (ld_align)
      2'd1:    ld_shifted = {8'h00, bus.rdata[31:8]};
      2'd2:    ld_shifted = {16'h0000, bus.rdata[31:16]};
      2'd3:    ld_shifted = {24'h000000, bus.rdata[31:24]};
      default: ld_shifted = bus.rdata;
    endcase
  end

  always_comb begin
    case (ld_func)
      LD_B:    ld_result = {{24{ld_shifted[7]}}, ld_shifted[7:0]};
      LD_BU:   ld_result = {24'h000000, ld_shifted[7:0]};
      LD_H:    ld_result = {{16{ld_shifted[15]}}, ld_shifted[15:0]};
      LD_HU:   ld_result = {16'h0000, ld_shifted[15:0]};
      default: ld_result = ld_shifted;
    endcase
  end

  assign rdata       = ld_result;
  assign rres_valid  = bus.rvalid;
  assign bus.rready  = rres_ready;

  // move store data into its byte lanes
  always_comb begin
    case (waddr[1:0])
      2'd1:    st_data = {wdata[23:0], 8'h00};
      2'd2:    st_data = {wdata[15:0], 16'h0000};
      2'd3:    st_data = {wdata[7:0], 24'h000000};
      default: st_data = wdata;
    endcase
  end

  // unshifted strobe, based at lane 0
  always_comb begin
    case (wfunc)
      ST_B:    st_mask = 4'b0001;
      ST_H:    st_mask = 4'b0011;
      default: st_mask = 4'b1111;
    endcase
  end

  assign st_strb = st_mask << waddr[1:0];

  // each channel sends once per store, both rearm on B
  always_ff @(posedge clk) begin
    if (!rstn) begin
      aw_pend <= 1'b1;
      w_pend  <= 1'b1;
    end else if (bus.bvalid && bus.bready) begin
      aw_pend <= 1'b1;
      w_pend  <= 1'b1;
    end else begin
      if (bus.awvalid && bus.awready) begin
        aw_pend <= 1'b0;
      end
      if (bus.wvalid && bus.wready) begin
        w_pend <= 1'b0;
      end
    end
  end

  assign bus.awvalid = wreq_valid && aw_pend;
  assign bus.awaddr  = waddr;
  assign bus.wvalid  = wreq_valid && w_pend;
  assign bus.wdata   = st_data;
  assign bus.wstrb   = st_strb;
  assign wreq_ready  = bus.awvalid && bus.awready && bus.wvalid && bus.wready;

  assign wres_valid  = bus.bvalid;
  assign bus.bready  = wres_ready;

endmodule

/* fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit #(
  parameter logic [31:0] reset_pc = 32'h0000_0000
) (
  input  logic        clk,
  input  logic        rstn,
  input  logic        redirect_valid,
  input  logic [31:0] redirect_pc,
  output logic [31:0] instr,
  output logic [31:0] instr_pc,
  output logic        instr_valid,
  input  logic        instr_ready,
  axi_lite_if.master  bus
);

  logic [31:0] pc;
  logic        req_q;
  logic [31:0] req_addr_q;
  logic        inflight;
  logic        drop;
  logic        buf_valid;
  logic [31:0] buf_data;
  logic [31:0] buf_pc;
  logic        can_issue;
  logic        ar_fire;
  logic        r_fire;
  logic        consume;

  // one outstanding read, issued only into an empty buffer
  assign can_issue   = !req_q && !inflight && !buf_valid;
  assign bus.arvalid = req_q || can_issue;
  assign bus.araddr  = req_q ? req_addr_q : pc;
  assign bus.rready  = !buf_valid;

  assign ar_fire = bus.arvalid && bus.arready;
  assign r_fire  = inflight && bus.rvalid && bus.rready;
  assign consume = buf_valid && instr_ready;

  // read only master
  assign bus.awvalid = 1'b0;
  assign bus.awaddr  = '0;
  assign bus.wvalid  = 1'b0;
  assign bus.wdata   = '0;
  assign bus.wstrb   = '0;
  assign bus.bready  = 1'b0;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      pc        <= reset_pc;
      req_q     <= 1'b0;
      inflight  <= 1'b0;
      drop      <= 1'b0;
      buf_valid <= 1'b0;
    end else begin
      // AR must stay up once raised
      req_q <= bus.arvalid && !bus.arready;
      if (ar_fire) begin
        inflight <= 1'b1;
      end else if (r_fire) begin
        inflight <= 1'b0;
      end
      if (r_fire) begin
        drop      <= 1'b0;
        buf_valid <= !drop;
      end
      if (consume) begin
        buf_valid <= 1'b0;
        pc        <= pc + 32'd4;
      end
      // anything still outstanding now belongs to the old stream
      if (redirect_valid) begin
        pc        <= redirect_pc;
        buf_valid <= 1'b0;
        drop      <= (inflight && !r_fire) || bus.arvalid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (can_issue) begin
      req_addr_q <= pc;
    end
    if (r_fire) begin
      buf_data <= bus.rdata;
      buf_pc   <= req_addr_q;
    end
  end

  assign instr       = buf_data;
  assign instr_pc    = buf_pc;
  assign instr_valid = buf_valid;

endmodule

/* axi_arbiter.sv */
`timescale 1ns/1ps

module axi_arbiter (
  input  logic      clk,
  input  logic      rstn,
  axi_lite_if.slave m0,
  axi_lite_if.slave m1,
  axi_lite_if.master s
);

  logic owned;
  logic owner;
  logic last;
  logic m0_req;
  logic m1_req;
  logic req_any;
  logic pick;
  logic sel;
  logic release_now;

  assign m0_req  = m0.arvalid || m0.awvalid || m0.wvalid;
  assign m1_req  = m1.arvalid || m1.awvalid || m1.wvalid;
  assign req_any = m0_req || m1_req;

  // round robin, on a tie the master not served last wins
  always_comb begin
    if (m0_req && m1_req) begin
      pick = !last;
    end else begin
      pick = m1_req;
    end
  end

  // grant is combinational when idle, so no extra cycle
  assign sel = owned ? owner : pick;

  // transaction ends with its read or write response
  assign release_now = owned && ((s.rvalid && s.rready) || (s.bvalid && s.bready));

  always_ff @(posedge clk) begin
    if (!rstn) begin
      owned <= 1'b0;
      owner <= 1'b0;
      last  <= 1'b0;
    end else if (!owned) begin
      if (req_any) begin
        owned <= 1'b1;
        owner <= pick;
      end
    end else if (release_now) begin
      owned <= 1'b0;
      last  <= owner;
    end
  end

  // requests toward the slave
  assign s.awvalid = sel ? m1.awvalid : m0.awvalid;
  assign s.awaddr  = sel ? m1.awaddr  : m0.awaddr;
  assign s.wvalid  = sel ? m1.wvalid  : m0.wvalid;
  assign s.wdata   = sel ? m1.wdata   : m0.wdata;
  assign s.wstrb   = sel ? m1.wstrb   : m0.wstrb;
  assign s.arvalid = sel ? m1.arvalid : m0.arvalid;
  assign s.araddr  = sel ? m1.araddr  : m0.araddr;
  assign s.bready  = sel ? m1.bready  : m0.bready;
  assign s.rready  = sel ? m1.rready  : m0.rready;

  // readies only to the granted master
  assign m0.awready = !sel && s.awready;
  assign m0.wready  = !sel && s.wready;
  assign m0.arready = !sel && s.arready;
  assign m1.awready = sel && s.awready;
  assign m1.wready  = sel && s.wready;
  assign m1.arready = sel && s.arready;

  // responses, data can be shared since valid is steered
  assign m0.bvalid = !sel && s.bvalid;
  assign m0.rvalid = !sel && s.rvalid;
  assign m0.rdata  = s.rdata;
  assign m1.bvalid = sel && s.bvalid;
  assign m1.rvalid = sel && s.rvalid;
  assign m1.rdata  = s.rdata;

endmodule

/* axi_sram.sv */
`timescale 1ns/1ps

module axi_sram #(
  parameter int mem_words = mem_pkg::MEM_WORDS_DEF
) (
  input  logic      clk,
  input  logic      rstn,
  axi_lite_if.slave bus
);
  import mem_pkg::*;

  localparam int idx_w = $clog2(mem_words);

  typedef enum logic [1:0] {
    S_IDLE,
    S_RD,
    S_WR
  } state_e;

  state_e            state;
  logic [DATA_W-1:0] mem [mem_words];
  logic [DATA_W-1:0] rdata_q;
  logic [idx_w-1:0]  rd_idx;
  logic [idx_w-1:0]  wr_idx;
  logic              rd_take;
  logic              wr_take;

  // word index above the byte offset, wraps at mem_words
  assign rd_idx = bus.araddr[idx_w+1:2];
  assign wr_idx = bus.awaddr[idx_w+1:2];

  // reads win a tie, writes need AW and W together
  assign bus.arready = (state == S_IDLE);
  assign rd_take     = bus.arvalid && bus.arready;
  assign wr_take     = (state == S_IDLE) && !bus.arvalid && bus.awvalid && bus.wvalid;
  assign bus.awready = wr_take;
  assign bus.wready  = wr_take;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE: begin
          if (rd_take) begin
            state <= S_RD;
          end else if (wr_take) begin
            state <= S_WR;
          end
        end
        S_RD: begin
          if (bus.rready) begin
            state <= S_IDLE;
          end
        end
        S_WR: begin
          if (bus.bready) begin
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rd_take) begin
      rdata_q <= mem[rd_idx];
    end
    if (wr_take) begin
      for (int i = 0; i < DATA_W / 8; i++) begin
        if (bus.wstrb[i]) begin
          mem[wr_idx][8*i +: 8] <= bus.wdata[8*i +: 8];
        end
      end
    end
  end

  assign bus.rvalid = (state == S_RD);
  assign bus.rdata  = rdata_q;
  assign bus.bvalid = (state == S_WR);

endmodule

/* mem_subsys_top.sv */
`timescale 1ns/1ps

module mem_subsys_top #(
  parameter int          mem_words = mem_pkg::MEM_WORDS_DEF,
  parameter logic [31:0] reset_pc  = 32'h0000_0000
) (
  input  logic              clk,
  input  logic              rstn,
  // instruction fetch
  input  logic              redirect_valid,
  input  logic [31:0]       redirect_pc,
  output logic [31:0]       instr,
  output logic [31:0]       instr_pc,
  output logic              instr_valid,
  input  logic              instr_ready,
  // loads
  input  logic [31:0]       raddr,
  input  mem_pkg::ld_func_e rfunc,
  input  logic              rreq_valid,
  output logic              rreq_ready,
  output logic [31:0]       rdata,
  output logic              rres_valid,
  input  logic              rres_ready,
  // stores
  input  logic [31:0]       waddr,
  input  logic [31:0]       wdata,
  input  mem_pkg::st_func_e wfunc,
  input  logic              wreq_valid,
  output logic              wreq_ready,
  output logic              wres_valid,
  input  logic              wres_ready
);

  axi_lite_if fetch_bus ();
  axi_lite_if lsu_bus ();
  axi_lite_if mem_bus ();

  fetch_unit #(
    .reset_pc (reset_pc)
  ) fetch_i (
    .clk            (clk),
    .rstn           (rstn),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .instr          (instr),
    .instr_pc       (instr_pc),
    .instr_valid    (instr_valid),
    .instr_ready    (instr_ready),
    .bus            (fetch_bus)
  );

  lsu lsu_i (
    .clk        (clk),
    .rstn       (rstn),
    .raddr      (raddr),
    .rfunc      (rfunc),
    .rreq_valid (rreq_valid),
    .rreq_ready (rreq_ready),
    .rdata      (rdata),
    .rres_valid (rres_valid),
    .rres_ready (rres_ready),
    .waddr      (waddr),
    .wdata      (wdata),
    .wfunc      (wfunc),
    .wreq_valid (wreq_valid),
    .wreq_ready (wreq_ready),
    .wres_valid (wres_valid),
    .wres_ready (wres_ready),
    .bus        (lsu_bus)
  );

  // fetch is master 0, lsu is master 1
  axi_arbiter arb_i (
    .clk  (clk),
    .rstn (rstn),
    .m0   (fetch_bus),
    .m1   (lsu_bus),
    .s    (mem_bus)
  );

  axi_sram #(
    .mem_words (mem_words)
  ) sram_i (
    .clk  (clk),
    .rstn (rstn),
    .bus  (mem_bus)
  );

endmodule

/* tb_checker.sv */
`timescale 1ns/1ps

module tb_checker (
  input  logic              clk,
  input  logic              redirect_valid,
  input  logic [31:0]       redirect_pc,
  input  logic [31:0]       instr,
  input  logic [31:0]       instr_pc,
  input  logic              instr_valid,
  input  logic              instr_ready,
  input  logic [31:0]       raddr,
  input  mem_pkg::ld_func_e rfunc,
  input  logic              rreq_valid,
  input  logic              rreq_ready,
  input  logic [31:0]       rdata,
  input  logic              rres_valid,
  input  logic              rres_ready,
  input  logic [31:0]       waddr,
  input  logic [31:0]       wdata,
  input  mem_pkg::st_func_e wfunc,
  input  logic              wreq_valid,
  input  logic              wreq_ready,
  input  logic              wres_valid,
  input  logic              wres_ready,
  input  logic              entry_done,
  input  int                entry_id,
  input  logic [31:0]       exp_ld,
  input  logic              chk_ld,
  output int                n_tests,
  output int                n_bad,
  output int                n_errs,
  output int                pending
);
  import mem_pkg::*;

  // byte model of memory, filled from observed stores
  logic [7:0]  model [logic [31:0]];
  logic [31:0] exp_q [$];
  logic [31:0] exp_pc;
  logic [31:0] last_rdata;
  logic [31:0] last_instr;
  logic [31:0] last_pc;
  bit          unknown;
  bit          armed;
  bit          hold_r;
  bit          hold_i;
  int          errs_mark;
  int          st_open;

  task automatic flag_mismatch(input string msg);
    n_errs++;
    $display("FAIL at %0t ns: %s", $time, msg);
  endtask

  task automatic flag_problem(input string msg);
    n_errs++;
    $display("error at %0t ns: %s", $time, msg);
  endtask

  function automatic logic [7:0] byte_at(input logic [31:0] a);
    if (model.exists(a)) begin
      byte_at = model[a];
    end else begin
      byte_at = 8'h00;
      unknown = 1'b1;
    end
  endfunction

  // selected bytes, little endian, extended per load code
  function automatic logic [31:0] load_value(input logic [31:0] a, input ld_func_e f);
    logic [7:0] b0;
    logic [7:0] b1;
    logic [7:0] b2;
    logic [7:0] b3;
    b0 = byte_at(a);
    b1 = 8'h00;
    b2 = 8'h00;
    b3 = 8'h00;
    if (f != LD_B && f != LD_BU) begin
      b1 = byte_at(a + 32'd1);
    end
    if (f == LD_W) begin
      b2 = byte_at(a + 32'd2);
      b3 = byte_at(a + 32'd3);
    end
    case (f)
      LD_B:    load_value = {{24{b0[7]}}, b0};
      LD_BU:   load_value = {24'h000000, b0};
      LD_H:    load_value = {{16{b1[7]}}, b1, b0};
      LD_HU:   load_value = {16'h0000, b1, b0};
      default: load_value = {b3, b2, b1, b0};
    endcase
  endfunction

  always @(negedge clk) begin
    logic [31:0] v;
    // a stalled reply must not move
    if (hold_r && (!rres_valid || rdata !== last_rdata)) begin
      flag_mismatch("load reply changed while stalled");
    end
    if (hold_i && (!instr_valid || instr !== last_instr || instr_pc !== last_pc)) begin
      flag_mismatch("fetched word changed while stalled");
    end
    hold_r     = rres_valid && !rres_ready;
    hold_i     = instr_valid && !instr_ready && !redirect_valid;
    last_rdata = rdata;
    last_instr = instr;
    last_pc    = instr_pc;

    // each accepted store gets exactly one write reply
    if (wres_valid && wres_ready) begin
      if (st_open == 0) begin
        flag_problem("a store reply arrived without a request");
      end else begin
        st_open--;
      end
    end

    if (wreq_valid && wreq_ready) begin
      st_open++;
      model[waddr] = wdata[7:0];
      if (wfunc != ST_B) begin
        model[waddr + 32'd1] = wdata[15:8];
      end
      if (wfunc == ST_W) begin
        model[waddr + 32'd2] = wdata[23:16];
        model[waddr + 32'd3] = wdata[31:24];
      end
    end

    if (rreq_valid && rreq_ready) begin
      unknown = 1'b0;
      v = load_value(raddr, rfunc);
      if (unknown) begin
        flag_problem($sformatf("load at %h reads memory that was never written", raddr));
      end
      exp_q.push_back(v);
    end
    if (rres_valid && rres_ready) begin
      if (exp_q.size() == 0) begin
        flag_problem("a load reply arrived without a request");
      end else begin
        v = exp_q.pop_front();
        if (rdata !== v) begin
          flag_mismatch($sformatf("load got %h, memory model gives %h", rdata, v));
        end
        if (chk_ld && rdata !== exp_ld) begin
          flag_mismatch($sformatf("load got %h, table gives %h", rdata, exp_ld));
        end
      end
    end

    // new stream starts at the redirect target
    if (redirect_valid) begin
      armed  = 1'b1;
      exp_pc = redirect_pc;
    end else if (armed && instr_valid && instr_ready) begin
      unknown = 1'b0;
      v = load_value(instr_pc, LD_W);
      if (instr_pc !== exp_pc) begin
        flag_mismatch($sformatf("fetch pc %h, expected %h", instr_pc, exp_pc));
      end else if (unknown) begin
        flag_problem($sformatf("fetch at %h reads memory that was never written", instr_pc));
      end else if (instr !== v) begin
        flag_mismatch($sformatf("fetch at %h got %h, expected %h", instr_pc, instr, v));
      end
      exp_pc = exp_pc + 32'd4;
    end

    if (entry_done) begin
      n_tests++;
      if (n_errs == errs_mark) begin
        $display("test %0d ok", entry_id);
      end else begin
        n_bad++;
        $display("test %0d failed", entry_id);
      end
      errs_mark = n_errs;
    end
    pending = exp_q.size() + st_open;
  end

endmodule

/* tb_top.sv */
`timescale 1ns/1ps

module tb_top;
  import mem_pkg::*;

  typedef enum logic [1:0] {
    K_ST,
    K_LD,
    K_FE,
    K_BOTH
  } kind_e;

  // fetch: addr is the target, n the word count
  // both: addr is the load, data the fetch target
  typedef struct packed {
    kind_e       kind;
    logic [31:0] addr;
    logic [2:0]  func;
    logic [31:0] data;
    logic [7:0]  n;
    logic [31:0] exp;
  } entry_t;

  logic        clk;
  logic        rstn;
  logic        redirect_valid;
  logic [31:0] redirect_pc;
  logic [31:0] instr;
  logic [31:0] instr_pc;
  logic        instr_valid;
  logic        instr_ready;
  logic [31:0] raddr;
  ld_func_e    rfunc;
  logic        rreq_valid;
  logic        rreq_ready;
  logic [31:0] rdata;
  logic        rres_valid;
  logic        rres_ready;
  logic [31:0] waddr;
  logic [31:0] wdata;
  st_func_e    wfunc;
  logic        wreq_valid;
  logic        wreq_ready;
  logic        wres_valid;
  logic        wres_ready;
  logic        entry_done;
  int          entry_id;
  logic [31:0] exp_ld;
  logic        chk_ld;
  int          n_tests;
  int          n_bad;
  int          n_errs;
  int          pending;
  logic [31:0] lfsr;
  int          cycles;
  int          limit;
  entry_t      tbl [$];

  mem_subsys_top #(
    .mem_words (MEM_WORDS_DEF),
    .reset_pc  (32'h0000_0000)
  ) dut_i (.*);

  tb_checker chk_i (.*);

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= limit) begin
      $display("timeout: the run did not finish within %0d cycles", limit);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      lfsr_next = (s >> 1) ^ 32'ha300_0000;
    end else begin
      lfsr_next = s >> 1;
    end
  endfunction

  function automatic void add_entry(input kind_e k, input logic [31:0] a, input logic [2:0] f,
                                    input logic [31:0] d, input logic [7:0] n,
                                    input logic [31:0] x);
    tbl.push_back('{k, a, f, d, n, x});
  endfunction

  task automatic fill_table();
    // known words first
    add_entry(K_ST, 32'h100, ST_W, 32'h1122_3344, 8'd0, 32'h0);
    add_entry(K_ST, 32'h104, ST_W, 32'h5566_7788, 8'd0, 32'h0);
    add_entry(K_ST, 32'h108, ST_W, 32'h8899_aabb, 8'd0, 32'h0);
    add_entry(K_ST, 32'h10c, ST_W, 32'hccdd_eeff, 8'd0, 32'h0);
    add_entry(K_ST, 32'h110, ST_W, 32'h0102_0304, 8'd0, 32'h0);
    add_entry(K_ST, 32'h114, ST_W, 32'h90a0_b0c0, 8'd0, 32'h0);
    // byte lanes, upper data bits are junk
    add_entry(K_ST, 32'h101, ST_B, 32'hdead_be5a, 8'd0, 32'h0);
    add_entry(K_ST, 32'h103, ST_B, 32'h1234_560f, 8'd0, 32'h0);
    add_entry(K_LD, 32'h100, LD_W, 32'h0, 8'd0, 32'h0f22_5a44);
    add_entry(K_ST, 32'h100, ST_B, 32'h0000_00a5, 8'd0, 32'h0);
    add_entry(K_ST, 32'h102, ST_B, 32'hffff_fff0, 8'd0, 32'h0);
    add_entry(K_LD, 32'h100, LD_W, 32'h0, 8'd0, 32'h0ff0_5aa5);
    add_entry(K_ST, 32'h104, ST_H, 32'h1234_8001, 8'd0, 32'h0);
    add_entry(K_LD, 32'h104, LD_W, 32'h0, 8'd0, 32'h5566_8001);
    add_entry(K_ST, 32'h105, ST_H, 32'hcafe_7ffe, 8'd0, 32'h0);
    add_entry(K_LD, 32'h104, LD_W, 32'h0, 8'd0, 32'h557f_fe01);
    add_entry(K_ST, 32'h106, ST_H, 32'h0000_beef, 8'd0, 32'h0);
    add_entry(K_LD, 32'h104, LD_W, 32'h0, 8'd0, 32'hbeef_fe01);
    // narrow loads at each offset
    add_entry(K_LD, 32'h108, LD_B, 32'h0, 8'd0, 32'hffff_ffbb);
    add_entry(K_LD, 32'h109, LD_BU, 32'h0, 8'd0, 32'h0000_00aa);
    add_entry(K_LD, 32'h10a, LD_B, 32'h0, 8'd0, 32'hffff_ff99);
    add_entry(K_LD, 32'h10b, LD_BU, 32'h0, 8'd0, 32'h0000_0088);
    add_entry(K_LD, 32'h10b, LD_B, 32'h0, 8'd0, 32'hffff_ff88);
    add_entry(K_LD, 32'h108, LD_H, 32'h0, 8'd0, 32'hffff_aabb);
    add_entry(K_LD, 32'h109, LD_HU, 32'h0, 8'd0, 32'h0000_99aa);
    add_entry(K_LD, 32'h10a, LD_H, 32'h0, 8'd0, 32'hffff_8899);
    add_entry(K_LD, 32'h10a, LD_HU, 32'h0, 8'd0, 32'h0000_8899);
    add_entry(K_LD, 32'h10c, LD_HU, 32'h0, 8'd0, 32'h0000_eeff);
    add_entry(K_LD, 32'h10d, LD_B, 32'h0, 8'd0, 32'hffff_ffee);
    add_entry(K_LD, 32'h10e, LD_BU, 32'h0, 8'd0, 32'h0000_00dd);
    add_entry(K_LD, 32'h10f, LD_B, 32'h0, 8'd0, 32'hffff_ffcc);
    add_entry(K_LD, 32'h110, LD_H, 32'h0, 8'd0, 32'h0000_0304);
    add_entry(K_LD, 32'h111, LD_B, 32'h0, 8'd0, 32'h0000_0003);
    add_entry(K_LD, 32'h112, LD_H, 32'h0, 8'd0, 32'h0000_0102);
    // second redirect lands while the next word is in flight
    add_entry(K_FE, 32'h100, 3'd0, 32'h0, 8'd4, 32'h0);
    add_entry(K_FE, 32'h108, 3'd0, 32'h0, 8'd2, 32'h0);
    add_entry(K_FE, 32'h104, 3'd0, 32'h0, 8'd3, 32'h0);
    add_entry(K_BOTH, 32'h114, LD_W, 32'h100, 8'd2, 32'h90a0_b0c0);
    add_entry(K_BOTH, 32'h112, LD_H, 32'h108, 8'd3, 32'h0000_0102);
    add_entry(K_BOTH, 32'h117, LD_B, 32'h10c, 8'd2, 32'hffff_ff90);
  endtask

  task automatic run_entry(input int k);
    entry_t e;
    logic   rdy;
    logic   st_on;
    logic   ld_on;
    logic   w_fire;
    logic   r_fire;
    int     words;
    e        = tbl[k];
    st_on    = (e.kind == K_ST);
    ld_on    = (e.kind == K_LD) || (e.kind == K_BOTH);
    words    = (e.kind == K_FE || e.kind == K_BOTH) ? int'(e.n) : 0;
    entry_id = k;
    if (words > 0) begin
      redirect_valid = 1'b1;
      redirect_pc    = (e.kind == K_FE) ? e.addr : e.data;
      @(posedge clk);
      #2;
      redirect_valid = 1'b0;
    end
    wreq_valid = st_on;
    waddr      = e.addr;
    wdata      = e.data;
    wfunc      = st_func_e'(e.func);
    wres_ready = st_on;
    rreq_valid = ld_on;
    raddr      = e.addr;
    rfunc      = ld_func_e'(e.func);
    exp_ld     = e.exp;
    chk_ld     = ld_on;
    while (st_on || ld_on || words > 0) begin
      lfsr        = lfsr_next(lfsr);
      rdy         = !lfsr[0];
      rres_ready  = ld_on && rdy;
      instr_ready = (words > 0) && rdy;
      // transfers are decided by the values seen here
      @(negedge clk);
      w_fire = wreq_valid && wreq_ready;
      r_fire = rreq_valid && rreq_ready;
      if (wres_valid && wres_ready) begin
        st_on = 1'b0;
      end
      if (rres_valid && rres_ready) begin
        ld_on = 1'b0;
      end
      if (instr_valid && instr_ready) begin
        words--;
      end
      @(posedge clk);
      #2;
      if (w_fire) begin
        wreq_valid = 1'b0;
      end
      if (r_fire) begin
        rreq_valid = 1'b0;
      end
    end
    wres_ready  = 1'b0;
    rres_ready  = 1'b0;
    instr_ready = 1'b0;
    chk_ld      = 1'b0;
    entry_done  = 1'b1;
    @(posedge clk);
    #2;
    entry_done = 1'b0;
  endtask

  initial begin
    clk            = 1'b0;
    rstn           = 1'b0;
    redirect_valid = 1'b0;
    redirect_pc    = 32'h0;
    instr_ready    = 1'b0;
    raddr          = 32'h0;
    rfunc          = LD_W;
    rreq_valid     = 1'b0;
    rres_ready     = 1'b0;
    waddr          = 32'h0;
    wdata          = 32'h0;
    wfunc          = ST_W;
    wreq_valid     = 1'b0;
    wres_ready     = 1'b0;
    entry_done     = 1'b0;
    entry_id       = 0;
    exp_ld         = 32'h0;
    chk_ld         = 1'b0;
    lfsr           = 32'h2dab6cae;
    cycles         = 0;
    fill_table();
    limit = 200 * tbl.size();
    repeat (10) @(posedge clk);
    #2;
    rstn = 1'b1;
    for (int k = 0; k < tbl.size(); k++) begin
      run_entry(k);
    end
    // room for a stray extra reply to show up
    repeat (4) @(posedge clk);
    if (pending != 0) begin
      $display("%0d load or store requests never got a reply", pending);
    end
    $display("tests %0d, tests failed %0d, errors %0d", n_tests, n_bad, n_errs);
    if (n_errs == 0 && n_bad == 0 && pending == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* mem_subsys.f */
mem_pkg.sv
axi_lite_if.sv
lsu.sv
fetch_unit.sv
axi_arbiter.sv
axi_sram.sv
mem_subsys_top.sv
tb_checker.sv
tb_top.sv

/* Makefile */
TOOL  = verilator
FLAGS = --binary --timing -j 0
TOP   = tb_top
FLIST = mem_subsys.f
LOG   = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
